//--- hw/sram_params.svh
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// Memory geometry
`define SRAM_DEPTH 256
`define SRAM_DATA_W 32

// SECDED codeword, data plus six Hamming checks and overall parity
`define SRAM_CODE_W 39

// Pipeline stages around the array
// Each enabled stage adds one cycle of read latency
`define SRAM_IN_PIPE 1
`define SRAM_OUT_PIPE 1

`endif

//--- hw/sram_pkg.sv
`include "sram_params.svh"

package sram_pkg;

  // Multi-bit encoded boolean for the internal strobes
  typedef logic [3:0] mubi4_t;

  parameter mubi4_t MuBi4True  = 4'b0110;
  parameter mubi4_t MuBi4False = 4'b1001;

  // Stored word, overall parity at bit 0 and Hamming checks at powers of two
  typedef logic [`SRAM_CODE_W-1:0] code_word_t;

  // Read error status
  typedef struct packed {
    logic uncorr;
    logic corr;
  } ecc_err_t;

  ////////////////////////////////////////////////////////////
  // Strobe helpers
  ////////////////////////////////////////////////////////////

  function automatic mubi4_t mubi4_from_bool(logic b);
    return b ? MuBi4True : MuBi4False;
  endfunction

  // Loose test, anything other than false reads as true
  function automatic logic mubi4_is_true(mubi4_t v);
    return v != MuBi4False;
  endfunction

  function automatic logic mubi4_is_invalid(mubi4_t v);
    return !(v == MuBi4True || v == MuBi4False);
  endfunction

  // Bitwise AND on the true-high bits and OR on the false-high bits,
  // so a corrupted operand stays visible as an invalid pattern
  function automatic mubi4_t mubi4_and(mubi4_t a, mubi4_t b);
    mubi4_t r;
    for (int k = 0; k < 4; k++) begin
      if (MuBi4True[k]) begin
        r[k] = a[k] & b[k];
      end else begin
        r[k] = a[k] | b[k];
      end
    end
    return r;
  endfunction

endpackage

//--- hw/sram_port_if.sv
`timescale 1ns/1ps
`include "sram_params.svh"

interface sram_port_if;
  import sram_pkg::*;

  localparam int AddrW = $clog2(`SRAM_DEPTH);

  // Plain strobes at the array side
  logic             req;
  logic             write;
  logic [AddrW-1:0] addr;
  code_word_t       wcode;

  // Registered read codeword from the array
  code_word_t       rcode;

  modport ctrl (
    output req, write, addr, wcode,
    input  rcode
  );

  modport mem (
    input  req, write, addr, wcode,
    output rcode
  );

endinterface

//--- hw/secded_39_32_enc.sv
`timescale 1ns/1ps
`include "sram_params.svh"

module secded_39_32_enc (
  input  logic [`SRAM_DATA_W-1:0] data_i,
  output sram_pkg::code_word_t    code_o
);
  import sram_pkg::*;

  localparam int CodeW = `SRAM_CODE_W;

  always_comb begin
    code_word_t  c;
    int unsigned d;
    c = '0;
    d = 0;

    // Data fills every position that is not a power of two
    for (int p = 1; p < CodeW; p++) begin
      if ((p & (p - 1)) != 0) begin
        c[p] = data_i[d];
        d++;
      end
    end

    // Check k covers all positions with index bit k set
    for (int k = 0; k < 6; k++) begin
      for (int p = 1; p < CodeW; p++) begin
        if (p[k] && (p != (1 << k))) begin
          c[1 << k] ^= c[p];
        end
      end
    end

    // Overall parity last, over data and checks
    c[0] = ^c[CodeW-1:1];
    code_o = c;
  end

endmodule

//--- hw/secded_39_32_dec.sv
`timescale 1ns/1ps
`include "sram_params.svh"

module secded_39_32_dec (
  input  sram_pkg::code_word_t    code_i,
  output logic [`SRAM_DATA_W-1:0] data_o,
  output sram_pkg::ecc_err_t      err_o
);
  import sram_pkg::*;

  localparam int CodeW = `SRAM_CODE_W;

  logic [5:0] syndrome;
  logic       par_err;
  code_word_t fixed;
  ecc_err_t   err;

  // Syndrome is the index of a single flipped position
  always_comb begin
    syndrome = '0;
    for (int p = 1; p < CodeW; p++) begin
      for (int k = 0; k < 6; k++) begin
        if (p[k]) begin
          syndrome[k] ^= code_i[p];
        end
      end
    end
  end

  // Whole word including bit 0 must have even parity
  assign par_err = ^code_i;

  always_comb begin
    fixed = code_i;
    err   = '0;
    if (par_err) begin
      // Odd number of flips, treat as one and repair it
      // A zero syndrome points at the parity bit itself
      err.corr = 1'b1;
      for (int p = 0; p < CodeW; p++) begin
        if (p == int'(syndrome)) begin
          fixed[p] = ~fixed[p];
        end
      end
    end else if (syndrome != '0) begin
      // Even flips with a nonzero syndrome, data left as read
      err.uncorr = 1'b1;
    end
  end

  // Pull the data back out of the non-check positions
  always_comb begin
    int unsigned d;
    d = 0;
    data_o = '0;
    for (int p = 1; p < CodeW; p++) begin
      if ((p & (p - 1)) != 0) begin
        data_o[d] = fixed[p];
        d++;
      end
    end
  end

  assign err_o = err;

  always_comb begin
    assert (!(err_o.corr && err_o.uncorr))
      else $error("decoder reports corrected and uncorrectable at once");
  end

endmodule

//--- hw/ram_1p_array.sv
`timescale 1ns/1ps
`include "sram_params.svh"

module ram_1p_array (
  input logic      clk_i,
  sram_port_if.mem mem
);
  import sram_pkg::*;

  localparam int Depth = `SRAM_DEPTH;

  code_word_t ram_q [Depth];

  ////////////////////////////////////////////////////////////
  // Single port, one operation per request cycle
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (mem.req) begin
      if (mem.write) begin
        ram_q[mem.addr] <= mem.wcode;
      end else begin
        // Read data holds until the next read
        mem.rcode <= ram_q[mem.addr];
      end
    end
  end

  // Wrapper must never address past the end of the array
  addr_in_range_a : assert property (
    @(posedge clk_i) mem.req |-> (int'(mem.addr) < Depth)
  ) else $error("request to address %0d beyond depth", mem.addr);

endmodule

//--- hw/ram_1p_ecc.sv
`timescale 1ns/1ps
`include "sram_params.svh"

module ram_1p_ecc (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_i,
  input  logic                            write_i,
  input  logic [$clog2(`SRAM_DEPTH)-1:0]  addr_i,
  input  logic [`SRAM_DATA_W-1:0]         wdata_i,
  input  sram_pkg::code_word_t            err_flip_i,
  output logic [`SRAM_DATA_W-1:0]         rdata_o,
  output logic                            rvalid_o,
  output sram_pkg::ecc_err_t              rerror_o,
  output logic                            alert_o,
  sram_port_if.ctrl                       sram_if
);
  import sram_pkg::*;

  localparam int AddrW = $clog2(`SRAM_DEPTH);
  localparam int DataW = `SRAM_DATA_W;

  // Encoded strobes
  mubi4_t           req_d;
  mubi4_t           write_d;
  mubi4_t           req_q;
  mubi4_t           write_q;
  mubi4_t           rvalid_sram_d;
  mubi4_t           rvalid_sram_q;
  mubi4_t           rvalid_q;

  // Payload
  logic [AddrW-1:0] addr_q;
  code_word_t       wcode_enc;
  code_word_t       wcode_d;
  code_word_t       wcode_q;
  logic [DataW-1:0] rdata_d;
  logic [DataW-1:0] rdata_q;
  ecc_err_t         rerror_d;
  ecc_err_t         rerror_masked;
  ecc_err_t         rerror_q;
  logic             rd_valid;

  ////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////

  assign req_d   = mubi4_from_bool(req_i);
  assign write_d = mubi4_from_bool(write_i);

  secded_39_32_enc u_enc (
    .data_i (wdata_i),
    .code_o (wcode_enc)
  );

  // Injected flips land in the stored word, reads are unaffected
  assign wcode_d = wcode_enc ^ err_flip_i;

  ////////////////////////////////////////////////////////////
  // Input stage
  ////////////////////////////////////////////////////////////

  if (`SRAM_IN_PIPE) begin : gen_in_reg
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        req_q   <= MuBi4False;
        write_q <= MuBi4False;
      end else begin
        req_q   <= req_d;
        write_q <= write_d;
      end
    end

    always_ff @(posedge clk_i) begin
      addr_q  <= addr_i;
      wcode_q <= wcode_d;
    end
  end else begin : gen_in_pass
    assign req_q   = req_d;
    assign write_q = write_d;
    assign addr_q  = addr_i;
    assign wcode_q = wcode_d;
  end

  assign sram_if.req   = mubi4_is_true(req_q);
  assign sram_if.write = mubi4_is_true(write_q);
  assign sram_if.addr  = addr_q;
  assign sram_if.wcode = wcode_q;

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  // Issued operation was a read, rcode is valid one edge later
  assign rvalid_sram_d = mubi4_and(req_q, ~write_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_sram_q <= MuBi4False;
    end else begin
      rvalid_sram_q <= rvalid_sram_d;
    end
  end

  secded_39_32_dec u_dec (
    .code_i (sram_if.rcode),
    .data_o (rdata_d),
    .err_o  (rerror_d)
  );

  // Stale codewords must not report errors
  assign rd_valid      = mubi4_is_true(rvalid_sram_q);
  assign rerror_masked = rerror_d & {2{rd_valid}};

  ////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////

  if (`SRAM_OUT_PIPE) begin : gen_out_reg
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rvalid_q <= MuBi4False;
        rerror_q <= '0;
      end else begin
        rvalid_q <= rvalid_sram_q;
        rerror_q <= rerror_masked;
      end
    end

    always_ff @(posedge clk_i) begin
      rdata_q <= rdata_d;
    end
  end else begin : gen_out_pass
    assign rvalid_q = rvalid_sram_q;
    assign rerror_q = rerror_masked;
    assign rdata_q  = rdata_d;
  end

  assign rvalid_o = mubi4_is_true(rvalid_q);
  assign rdata_o  = rdata_q;
  assign rerror_o = rerror_q;

  // Any corrupted strobe register raises the alert
  assign alert_o = mubi4_is_invalid(req_q) | mubi4_is_invalid(write_q) |
                   mubi4_is_invalid(rvalid_sram_q) | mubi4_is_invalid(rvalid_q);

  rerror_needs_valid_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !rvalid_o |-> (rerror_o == '0)
  ) else $error("error status set without a read response");

  no_alert_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !alert_o
  ) else $error("invalid strobe encoding in the wrapper");

endmodule

//--- hw/ram_1p_top.sv
`timescale 1ns/1ps
`include "sram_params.svh"

module ram_1p_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic                           write_i,
  input  logic [$clog2(`SRAM_DEPTH)-1:0] addr_i,
  input  logic [`SRAM_DATA_W-1:0]        wdata_i,
  input  sram_pkg::code_word_t           err_flip_i,
  output logic [`SRAM_DATA_W-1:0]        rdata_o,
  output logic                           rvalid_o,
  output sram_pkg::ecc_err_t             rerror_o,
  output logic                           alert_o
);

  // Link between the ECC wrapper and the codeword array
  sram_port_if u_port_if ();

  ram_1p_ecc u_ecc (
    .clk_i,
    .rst_ni,
    .req_i,
    .write_i,
    .addr_i,
    .wdata_i,
    .err_flip_i,
    .rdata_o,
    .rvalid_o,
    .rerror_o,
    .alert_o,
    .sram_if    (u_port_if.ctrl)
  );

  ram_1p_array u_array (
    .clk_i,
    .mem        (u_port_if.mem)
  );

endmodule

//--- testbench/tb_ram_1p_top.sv
`timescale 1ns/1ps
`include "sram_params.svh"

module tb_ram_1p_top;
  import sram_pkg::*;

  localparam int AddrW = $clog2(`SRAM_DEPTH);
  localparam int DataW = `SRAM_DATA_W;
  localparam int CodeW = `SRAM_CODE_W;
  localparam int Lat = `SRAM_IN_PIPE + `SRAM_OUT_PIPE;
  localparam int DrainLimit = 4 * Lat + 10;

  typedef struct packed {
    logic [DataW-1:0] data;
    ecc_err_t         err;
  } exp_t;

  // Expected response tagged with the edge that took the request
  typedef struct packed {
    int   issue;
    exp_t exp;
  } pend_t;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             req_i;
  logic             write_i;
  logic [AddrW-1:0] addr_i;
  logic [DataW-1:0] wdata_i;
  code_word_t       err_flip_i;
  logic [DataW-1:0] rdata_o;
  logic             rvalid_o;
  ecc_err_t         rerror_o;
  logic             alert_o;

  int               cyc;
  logic [15:0]      lfsr_q;
  pend_t            pending [$];
  logic [DataW-1:0] shadow_data [`SRAM_DEPTH];
  code_word_t       shadow_flip [`SRAM_DEPTH];
  logic             written [`SRAM_DEPTH];

  ram_1p_top i_ram_1p_top (
    .clk_i,
    .rst_ni,
    .req_i,
    .write_i,
    .addr_i,
    .wdata_i,
    .err_flip_i,
    .rdata_o,
    .rvalid_o,
    .rerror_o,
    .alert_o
  );

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  // Rising edges since time zero
  initial begin
    cyc = 0;
    forever begin
      @(posedge clk_i);
      cyc++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random source and model
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Encode and apply the stored flips before decoding as a reader would
  function automatic exp_t exp_read(logic [DataW-1:0] data, code_word_t flip);
    code_word_t  c;
    logic [5:0]  acc;
    logic [5:0]  syn;
    int unsigned d;
    exp_t        r;
    c = '0;
    acc = '0;
    d = 0;
    for (int p = 1; p < CodeW; p++) begin
      if ((p & (p - 1)) != 0) begin
        c[p] = data[d];
        d++;
        if (c[p]) acc ^= 6'(p);
      end
    end
    for (int k = 0; k < 6; k++) begin
      c[1 << k] = acc[k];
    end
    c[0] = ^c[CodeW-1:1];
    c = c ^ flip;
    syn = '0;
    for (int p = 1; p < CodeW; p++) begin
      if (c[p]) syn ^= 6'(p);
    end
    r.err = '0;
    if (^c) begin
      r.err.corr = 1'b1;
      if (int'(syn) < CodeW) c[syn] = ~c[syn];
    end else if (syn != '0) begin
      r.err.uncorr = 1'b1;
    end
    d = 0;
    for (int p = 1; p < CodeW; p++) begin
      if ((p & (p - 1)) != 0) begin
        r.data[d] = c[p];
        d++;
      end
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input logic [DataW-1:0] got,
                            input logic [DataW-1:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "data mismatch on %s", name);
    end
  endtask

  task automatic check_err(input string name, input ecc_err_t got, input ecc_err_t exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %b, expected %b", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "error status mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %b, expected %b", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "level mismatch on %s", name);
    end
  endtask

  // Compare the outputs once per cycle against the oldest expected read
  initial begin
    pend_t head;
    forever begin
      @(negedge clk_i);
      check_bit("alert_o", alert_o, 1'b0);
      if (pending.size() != 0 && pending[0].issue + Lat == cyc) begin
        head = pending.pop_front();
        check_bit("rvalid_o", rvalid_o, 1'b1);
        check_err("rerror_o", rerror_o, head.exp.err);
        if (!head.exp.err.uncorr) begin
          check_data("rdata_o", rdata_o, head.exp.data);
        end
      end else begin
        check_bit("rvalid_o", rvalid_o, 1'b0);
        check_err("rerror_o", rerror_o, '0);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_write(input logic [AddrW-1:0] addr, input logic [DataW-1:0] data,
                             input code_word_t flip);
    @(negedge clk_i);
    req_i = 1'b1;
    write_i = 1'b1;
    addr_i = addr;
    wdata_i = data;
    err_flip_i = flip;
    shadow_data[addr] = data;
    shadow_flip[addr] = flip;
    written[addr] = 1'b1;
  endtask

  task automatic drive_read(input logic [AddrW-1:0] addr);
    pend_t p;
    @(negedge clk_i);
    req_i = 1'b1;
    write_i = 1'b0;
    addr_i = addr;
    // Flip mask must have no effect on a read
    err_flip_i = '1;
    p.issue = cyc + 1;
    p.exp = exp_read(shadow_data[addr], shadow_flip[addr]);
    pending.push_back(p);
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      req_i = 1'b0;
      write_i = 1'b0;
      err_flip_i = '0;
    end
  endtask

  task automatic wait_drain(output bit ok);
    int waited;
    waited = 0;
    while (pending.size() != 0 && waited < DrainLimit) begin
      drive_idle(1);
      waited++;
    end
    ok = (pending.size() == 0);
  endtask

  task automatic drain_between_phases();
    bit ok;
    wait_drain(ok);
    if (!ok) begin
      $display("Read responses still missing after %0d idle cycles", DrainLimit);
      $display("** FAIL **");
      $fatal(1, "response timeout");
    end
  endtask

  initial begin
    int unsigned      pos;
    int unsigned      pos2;
    logic [AddrW-1:0] a;
    code_word_t       flip;
    logic [AddrW-1:0] list [16];
    bit               ok;
    lfsr_q = 16'd28484;
    rst_ni = 1'b0;
    req_i = 1'b0;
    write_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    err_flip_i = '0;
    for (int i = 0; i < `SRAM_DEPTH; i++) begin
      written[i] = 1'b0;
    end
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    drive_idle(5);

    // Clean writes followed by a read of each
    for (int i = 0; i < 16; i++) begin
      list[i] = AddrW'(rand_bits(AddrW));
      drive_write(list[i], rand_bits(DataW), '0);
    end
    drive_idle(3);
    for (int i = 0; i < 16; i++) begin
      drive_read(list[i]);
    end
    drain_between_phases();

    // Single flips on the parity bit and each check position before random ones
    for (int i = 0; i < 16; i++) begin
      if (i == 0) pos = 0;
      else if (i < 7) pos = 1 << (i - 1);
      else pos = rand_bits(6) % CodeW;
      flip = '0;
      flip[pos] = 1'b1;
      a = AddrW'(rand_bits(AddrW));
      drive_write(a, rand_bits(DataW), flip);
      drive_read(a);
    end
    drain_between_phases();

    // Double flips at two distinct positions
    for (int i = 0; i < 12; i++) begin
      pos = rand_bits(6) % CodeW;
      pos2 = (pos + 1 + (rand_bits(6) % (CodeW - 1))) % CodeW;
      flip = '0;
      flip[pos] = 1'b1;
      flip[pos2] = 1'b1;
      a = AddrW'(rand_bits(AddrW));
      drive_write(a, rand_bits(DataW), flip);
      drive_read(a);
    end
    drain_between_phases();

    // Mixed traffic on a small window so reads often follow writes
    for (int i = 0; i < 80; i++) begin
      a = AddrW'(rand_bits(4));
      if (rand_bits(1) == 1 || !written[a]) begin
        drive_write(a, rand_bits(DataW), '0);
      end else begin
        drive_read(a);
      end
    end

    wait_drain(ok);
    drive_idle(4);
    if (ok) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("Read responses still missing after %0d idle cycles", DrainLimit);
      $display("** FAIL **");
      $fatal(1, "response timeout");
    end
  end

endmodule

//--- verilog.f
+incdir+hw
hw/sram_pkg.sv
hw/sram_port_if.sv
hw/secded_39_32_enc.sv
hw/secded_39_32_dec.sv
hw/ram_1p_array.sv
hw/ram_1p_ecc.sv
hw/ram_1p_top.sv
testbench/tb_ram_1p_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f verilog.f \
  --top-module tb_ram_1p_top -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q -F -- "** PASS **" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
